//--- src/rvPkg.sv
package rvPkg;

    localparam int XLEN    = 32;                      // data width
    localparam int REGADDR = 5;                       // register index width

    localparam logic [6:0] OPC_OP     = 7'b0110011;   // register-register alu
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;   // register-immediate alu
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,                                       // signed compare
        aluSltu,                                      // unsigned compare
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB                                      // lui path
    } aluOpT;

    typedef enum logic [2:0] {
        brNone,
        brEq,
        brNe,
        brLt,
        brGe,
        brLtu,
        brGeu
    } brOpT;

    typedef enum logic {opAReg, opAPc} opASelT;       // alu operand a source
    typedef enum logic {opBReg, opBImm} opBSelT;      // alu operand b source

    typedef enum logic [1:0] {pcSeq, pcBranch, pcJal, pcJalr} pcSelT;

    typedef struct packed {
        logic   regWrite;                             // rd gets written
        opASelT opASel;
        opBSelT opBSel;
        aluOpT  aluOp;
        brOpT   brOp;
        pcSelT  pcSel;
        logic   linkWrite;                            // result is pc+4
        logic   illegal;                              // opcode not supported
    } ctrlT;

    typedef struct packed {
        logic               valid;
        logic [XLEN-1:0]    pc;
        logic [REGADDR-1:0] rd;
        logic [XLEN-1:0]    rs1Data;
        logic [XLEN-1:0]    rs2Data;
        logic [XLEN-1:0]    imm;                      // already sign extended
        ctrlT               ctrl;
    } decodeOutT;

    typedef struct packed {
        logic               wbEn;
        logic [REGADDR-1:0] wbAddr;
        logic [XLEN-1:0]    wbData;
    } wbT;

    typedef struct packed {
        logic            redirectEn;
        logic [XLEN-1:0] targetPc;
    } redirectT;

endpackage

//--- src/controlDecoder.sv
module controlDecoder (
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic        funct7b5,                     // sub/sra select
    output rvPkg::ctrlT ctrl
);

    rvPkg::aluOpT opAlu;                              // alu op from funct fields

    // funct3 to alu op, shared by OP and OP-IMM
    always_comb
    begin
        case (funct3)
            3'b000:  opAlu = rvPkg::aluAdd;
            3'b001:  opAlu = rvPkg::aluSll;
            3'b010:  opAlu = rvPkg::aluSlt;
            3'b011:  opAlu = rvPkg::aluSltu;
            3'b100:  opAlu = rvPkg::aluXor;
            3'b101:  opAlu = funct7b5 ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  opAlu = rvPkg::aluOr;
            default: opAlu = rvPkg::aluAnd;
        endcase
    end

    always_comb
    begin
        ctrl.regWrite  = 1'b0;                        // defaults describe a nop
        ctrl.opASel    = rvPkg::opAReg;
        ctrl.opBSel    = rvPkg::opBReg;
        ctrl.aluOp     = rvPkg::aluAdd;
        ctrl.brOp      = rvPkg::brNone;
        ctrl.pcSel     = rvPkg::pcSeq;
        ctrl.linkWrite = 1'b0;
        ctrl.illegal   = 1'b0;
        case (opcode)
            rvPkg::OPC_OP:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = (funct3 == 3'b000 && funct7b5) ? rvPkg::aluSub : opAlu;
            end
            rvPkg::OPC_OPIMM:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.opBSel   = rvPkg::opBImm;
                ctrl.aluOp    = opAlu;                // no subi, b5 only picks srai
            end
            rvPkg::OPC_LUI:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.opBSel   = rvPkg::opBImm;
                ctrl.aluOp    = rvPkg::aluPassB;      // upper imm straight through
            end
            rvPkg::OPC_AUIPC:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.opASel   = rvPkg::opAPc;
                ctrl.opBSel   = rvPkg::opBImm;
            end
            rvPkg::OPC_BRANCH:
            begin
                ctrl.pcSel = rvPkg::pcBranch;
                case (funct3)
                    3'b000:  ctrl.brOp = rvPkg::brEq;
                    3'b001:  ctrl.brOp = rvPkg::brNe;
                    3'b100:  ctrl.brOp = rvPkg::brLt;
                    3'b101:  ctrl.brOp = rvPkg::brGe;
                    3'b110:  ctrl.brOp = rvPkg::brLtu;
                    3'b111:  ctrl.brOp = rvPkg::brGeu;
                    default: ctrl.illegal = 1'b1;     // 010 and 011 unused
                endcase
            end
            rvPkg::OPC_JAL:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.linkWrite = 1'b1;
                ctrl.pcSel     = rvPkg::pcJal;
            end
            rvPkg::OPC_JALR:
            begin
                ctrl.regWrite  = funct3 == 3'b000;
                ctrl.linkWrite = 1'b1;
                ctrl.pcSel     = rvPkg::pcJalr;
                ctrl.illegal   = funct3 != 3'b000;    // only funct3 0 defined
            end
            default:
            begin
                ctrl.illegal = 1'b1;                  // loads, stores, csr etc
            end
        endcase
    end

endmodule

//--- src/decodeStage.sv
module decodeStage (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        instrValid,   // level from frontend
    input  logic [rvPkg::XLEN-1:0]      instr,
    input  logic [rvPkg::XLEN-1:0]      pc,
    input  logic                        flush,        // taken redirect in execute
    output logic [rvPkg::REGADDR-1:0]   rs1Addr,
    output logic [rvPkg::REGADDR-1:0]   rs2Addr,
    input  logic [rvPkg::XLEN-1:0]      rs1Data,
    input  logic [rvPkg::XLEN-1:0]      rs2Data,
    output rvPkg::decodeOutT            decodeOut
);

    logic                   validReg;
    logic [rvPkg::XLEN-1:0] instrReg;
    logic [rvPkg::XLEN-1:0] pcReg;
    logic [6:0]             opcode;
    logic [rvPkg::XLEN-1:0] iImm;
    logic [rvPkg::XLEN-1:0] bImm;
    logic [rvPkg::XLEN-1:0] uImm;
    logic [rvPkg::XLEN-1:0] jImm;
    rvPkg::ctrlT            ctrl;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            validReg <= 1'b0;
        else
            validReg <= instrValid && !flush;         // squash the younger slot
    end

    always_ff @(posedge clk)
    begin
        instrReg <= instr;                            // payload, no reset
        pcReg    <= pc;
    end

    assign opcode  = instrReg[6:0];
    assign rs1Addr = instrReg[19:15];
    assign rs2Addr = instrReg[24:20];

    assign iImm = {{20{instrReg[31]}}, instrReg[31:20]};
    assign bImm = {{19{instrReg[31]}}, instrReg[31], instrReg[7], instrReg[30:25],
                   instrReg[11:8], 1'b0};
    assign uImm = {instrReg[31:12], 12'b0};
    assign jImm = {{11{instrReg[31]}}, instrReg[31], instrReg[19:12], instrReg[20],
                   instrReg[30:21], 1'b0};

    controlDecoder ctrlDec (
        .opcode   (opcode),
        .funct3   (instrReg[14:12]),
        .funct7b5 (instrReg[30]),
        .ctrl     (ctrl)
    );

    always_comb
    begin
        decodeOut.valid   = validReg;
        decodeOut.pc      = pcReg;
        decodeOut.rd      = instrReg[11:7];
        decodeOut.rs1Data = rs1Data;                  // same-cycle regfile read
        decodeOut.rs2Data = rs2Data;
        decodeOut.ctrl    = ctrl;
        case (opcode)
            rvPkg::OPC_OPIMM, rvPkg::OPC_JALR: decodeOut.imm = iImm;
            rvPkg::OPC_BRANCH:                 decodeOut.imm = bImm;
            rvPkg::OPC_LUI, rvPkg::OPC_AUIPC:  decodeOut.imm = uImm;
            rvPkg::OPC_JAL:                    decodeOut.imm = jImm;
            default:                           decodeOut.imm = '0;   // OP has none
        endcase
    end

    // the stimulus program holds only supported instructions
    validNotIllegal: assert property (@(posedge clk) disable iff (!nrst)
        validReg |-> !ctrl.illegal);

endmodule

//--- src/regFile.sv
module regFile (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic [rvPkg::REGADDR-1:0]   rs1Addr,
    input  logic [rvPkg::REGADDR-1:0]   rs2Addr,
    output logic [rvPkg::XLEN-1:0]      rs1Data,
    output logic [rvPkg::XLEN-1:0]      rs2Data,
    input  rvPkg::wbT                   wb            // write port from execute
);

    logic [rvPkg::XLEN-1:0] regs [1:31];              // x0 not stored

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.wbEn && wb.wbAddr != '0)          // x0 writes dropped
        begin
            regs[wb.wbAddr] <= wb.wbData;
        end
    end

    // reads see the old value on a same-cycle write
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    writeDataKnown: assert property (@(posedge clk) disable iff (!nrst)
        wb.wbEn |-> !$isunknown(wb.wbData));

endmodule

//--- src/executeStage.sv
module executeStage (
    input  logic                clk,
    input  logic                nrst,
    input  rvPkg::decodeOutT    decodeOut,
    output logic                flush,                // squash decode capture
    output rvPkg::wbT           wb,
    output rvPkg::redirectT     redirect
);

    logic [rvPkg::XLEN-1:0]    opA;
    logic [rvPkg::XLEN-1:0]    opB;
    logic [rvPkg::XLEN-1:0]    aluResult;
    logic [rvPkg::XLEN-1:0]    linkPc;                // pc+4
    logic [rvPkg::XLEN-1:0]    target;
    logic                      brTaken;
    logic                      taken;
    logic                      wbEnReg;
    logic [rvPkg::REGADDR-1:0] wbAddrReg;
    logic [rvPkg::XLEN-1:0]    wbDataReg;
    logic                      redirectEnReg;
    logic [rvPkg::XLEN-1:0]    targetReg;

    assign opA = (decodeOut.ctrl.opASel == rvPkg::opAPc) ? decodeOut.pc : decodeOut.rs1Data;
    assign opB = (decodeOut.ctrl.opBSel == rvPkg::opBImm) ? decodeOut.imm : decodeOut.rs2Data;

    always_comb
    begin
        case (decodeOut.ctrl.aluOp)
            rvPkg::aluAdd:   aluResult = opA + opB;
            rvPkg::aluSub:   aluResult = opA - opB;
            rvPkg::aluSll:   aluResult = opA << opB[4:0];      // shamt in low bits
            rvPkg::aluSlt:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
            rvPkg::aluSltu:  aluResult = {31'b0, opA < opB};
            rvPkg::aluXor:   aluResult = opA ^ opB;
            rvPkg::aluSrl:   aluResult = opA >> opB[4:0];
            rvPkg::aluSra:   aluResult = $signed(opA) >>> opB[4:0];
            rvPkg::aluOr:    aluResult = opA | opB;
            rvPkg::aluAnd:   aluResult = opA & opB;
            default:         aluResult = opB;                  // passB for lui
        endcase
    end

    always_comb
    begin
        case (decodeOut.ctrl.brOp)
            rvPkg::brEq:  brTaken = decodeOut.rs1Data == decodeOut.rs2Data;
            rvPkg::brNe:  brTaken = decodeOut.rs1Data != decodeOut.rs2Data;
            rvPkg::brLt:  brTaken = $signed(decodeOut.rs1Data) < $signed(decodeOut.rs2Data);
            rvPkg::brGe:  brTaken = $signed(decodeOut.rs1Data) >= $signed(decodeOut.rs2Data);
            rvPkg::brLtu: brTaken = decodeOut.rs1Data < decodeOut.rs2Data;
            rvPkg::brGeu: brTaken = decodeOut.rs1Data >= decodeOut.rs2Data;
            default:      brTaken = 1'b0;
        endcase
    end

    assign linkPc = decodeOut.pc + 32'd4;
    assign target = (decodeOut.ctrl.pcSel == rvPkg::pcJalr)
                  ? ((decodeOut.rs1Data + decodeOut.imm) & ~32'd1)   // jalr drops bit 0
                  : (decodeOut.pc + decodeOut.imm);

    always_comb
    begin
        case (decodeOut.ctrl.pcSel)
            rvPkg::pcBranch:           taken = decodeOut.valid && brTaken;
            rvPkg::pcJal, rvPkg::pcJalr: taken = decodeOut.valid;
            default:                   taken = 1'b0;
        endcase
    end

    assign flush = taken;                             // redirect before the flop

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            wbEnReg       <= 1'b0;
            redirectEnReg <= 1'b0;
        end
        else
        begin
            wbEnReg       <= decodeOut.valid && decodeOut.ctrl.regWrite;
            redirectEnReg <= taken;
        end
    end

    always_ff @(posedge clk)
    begin
        wbAddrReg <= decodeOut.rd;
        wbDataReg <= decodeOut.ctrl.linkWrite ? linkPc : aluResult;
        targetReg <= target;
    end

    assign wb.wbEn              = wbEnReg;
    assign wb.wbAddr            = wbAddrReg;
    assign wb.wbData            = wbDataReg;
    assign redirect.redirectEn  = redirectEnReg;
    assign redirect.targetPc    = targetReg;

    // no compressed support, so every target is word aligned
    targetAligned: assert property (@(posedge clk) disable iff (!nrst)
        redirect.redirectEn |-> redirect.targetPc[1:0] == 2'b00);

endmodule

//--- src/coreTop.sv
module coreTop (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    instrValid,       // one instruction per cycle
    input  logic [rvPkg::XLEN-1:0]  instr,
    input  logic [rvPkg::XLEN-1:0]  pc,
    output rvPkg::wbT               wb,
    output rvPkg::redirectT         redirect
);

    logic [rvPkg::REGADDR-1:0] rs1Addr;
    logic [rvPkg::REGADDR-1:0] rs2Addr;
    logic [rvPkg::XLEN-1:0]    rs1Data;
    logic [rvPkg::XLEN-1:0]    rs2Data;
    rvPkg::decodeOutT          decodeOut;             // decode to execute
    logic                      flush;

    decodeStage decode (
        .clk        (clk),
        .nrst       (nrst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .flush      (flush),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .decodeOut  (decodeOut)
    );

    regFile regs (
        .clk     (clk),
        .nrst    (nrst),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wb      (wb)                                 // writeback loops back here
    );

    executeStage execute (
        .clk       (clk),
        .nrst      (nrst),
        .decodeOut (decodeOut),
        .flush     (flush),
        .wb        (wb),
        .redirect  (redirect)
    );

endmodule

//--- verification/coreTopTb.sv
module coreTopTb;

    logic            clk;
    logic            nrst;
    logic            instrValid;
    logic [31:0]     instr;
    logic [31:0]     pc;
    rvPkg::wbT       wb;
    rvPkg::redirectT redirect;

    rvPkg::wbT       expWbQ [$];                      // expected results, oldest first
    rvPkg::redirectT expRdQ [$];
    string           nameQ [$];
    bit              lineQ [$];                       // slot came from the stimulus file
    int              busySlots;                       // file slots still in flight

    logic [31:0]     seed;                            // lcg state for idle gaps
    int              fd;

    coreTop UUT (
        .clk        (clk),
        .nrst       (nrst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .wb         (wb),
        .redirect   (redirect)
    );

    always #5 clk = ~clk;                             // 10 unit period

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic failRun(input string why);
        $display("%s", why);                          // plain reason first
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic expectSlot(input rvPkg::wbT expWb, input rvPkg::redirectT expRd,
                              input string name, input bit isLine);
        expWbQ.push_back(expWb);
        expRdQ.push_back(expRd);
        nameQ.push_back(name);
        lineQ.push_back(isLine);
        if (isLine)
            busySlots++;
    endtask

    // one pipeline slot: check the result of the slot driven two edges back, then drive
    task automatic runSlot(input logic valid, input logic [31:0] slotInstr,
                           input logic [31:0] slotPc, input rvPkg::wbT expWb,
                           input rvPkg::redirectT expRd, input string name);
        rvPkg::wbT       wbFront;
        rvPkg::redirectT rdFront;
        string           nameFront;
        bit              lineFront;
        @(posedge clk);
        #1;                                           // outputs settled after the edge
        if (expWbQ.size() == 2)
        begin
            wbFront   = expWbQ.pop_front();
            rdFront   = expRdQ.pop_front();
            nameFront = nameQ.pop_front();
            lineFront = lineQ.pop_front();
            if (lineFront)
                busySlots--;
            checkValue({nameFront, " wbEn"}, {31'b0, wbFront.wbEn}, {31'b0, wb.wbEn});
            if (wbFront.wbEn)
            begin
                checkValue({nameFront, " wbAddr"}, {27'b0, wbFront.wbAddr}, {27'b0, wb.wbAddr});
                checkValue({nameFront, " wbData"}, wbFront.wbData, wb.wbData);
            end
            checkValue({nameFront, " redirectEn"}, {31'b0, rdFront.redirectEn},
                       {31'b0, redirect.redirectEn});
            if (rdFront.redirectEn)
                checkValue({nameFront, " targetPc"}, rdFront.targetPc, redirect.targetPc);
        end
        instrValid = valid;
        instr      = slotInstr;
        pc         = slotPc;
        expectSlot(expWb, expRd, name, valid);
    endtask

    initial
    begin
        string           lineBuf;
        logic [31:0]     col [0:6];                   // instr pc wbEn wbAddr wbData rdEn target
        rvPkg::wbT       expWb;
        rvPkg::redirectT expRd;
        int              code;
        int              lineCount;
        int              readCount;
        int              gap;
        int              drainCycles;
        clk        = 1'b0;
        nrst       = 1'b0;
        instrValid = 1'b0;
        instr      = 32'h00000013;                    // nop
        pc         = 32'h0;
        seed       = 32'h5ae1;
        busySlots  = 0;
        lineCount  = 0;
        readCount  = 0;
        fd = $fopen("verification/coreStimulus.txt", "r");
        if (fd == 0)
            failRun("cannot open verification/coreStimulus.txt");
        for (int i = 0; i < 8; i++)
        begin
            @(posedge clk);
            #1;
            checkValue("reset wbEn", 32'd0, {31'b0, wb.wbEn});
            checkValue("reset redirectEn", 32'd0, {31'b0, redirect.redirectEn});
        end
        nrst = 1'b1;
        expectSlot('0, '0, "after reset", 1'b0);     // slot captured while in reset
        while (!$feof(fd))
        begin
            readCount++;
            if (readCount > 200)
                failRun("stimulus file has more lines than expected");
            code = $fgets(lineBuf, fd);
            if (code == 0 || lineBuf.len() < 8 || lineBuf.substr(0, 1) == "//")
                continue;                             // blank or column comment
            code = $sscanf(lineBuf, "%h %h %h %h %h %h %h",
                           col[0], col[1], col[2], col[3], col[4], col[5], col[6]);
            if (code != 7)
                failRun("stimulus line does not hold seven hex fields");
            lineCount++;
            expWb.wbEn       = col[2][0];
            expWb.wbAddr     = col[3][4:0];
            expWb.wbData     = col[4];
            expRd.redirectEn = col[5][0];
            expRd.targetPc   = col[6];
            runSlot(1'b1, col[0], col[1], expWb, expRd, $sformatf("line %0d", lineCount));
            // fall-through after a redirect must sit in the very next slot
            if (!expRd.redirectEn)
            begin
                seed = lcgNext(seed);
                gap  = (seed >> 16) % 3;
                for (int g = 0; g < gap; g++)
                begin
                    runSlot(1'b0, 32'h00000013, col[1], '0, '0, "idle");
                end
            end
        end
        $fclose(fd);
        drainCycles = 0;
        while (busySlots > 0)
        begin
            if (drainCycles == 8)
                failRun("pipeline did not drain within 8 cycles");
            runSlot(1'b0, 32'h00000013, pc, '0, '0, "idle");
            drainCycles++;
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- verification/coreStimulus.txt
// columns: instr pc expWbEn expWbAddr expWbData expRedirectEn expTarget, all hex
// the line after a taken branch or jump is squashed and expects no writeback or redirect
00500093 00000000 1 01 00000005 0 00000000
ffd00113 00000004 1 02 fffffffd 0 00000000
123451b7 00000008 1 03 12345000 0 00000000
00208233 0000000c 1 04 00000002 0 00000000
402082b3 00000010 1 05 00000008 0 00000000
40115333 00000014 1 06 ffffffff 0 00000000
4041d393 00000018 1 07 01234500 0 00000000
00112433 0000001c 1 08 00000001 0 00000000
001134b3 00000020 1 09 00000000 0 00000000
00001517 00000024 1 0a 00001024 0 00000000
00708013 00000028 1 00 0000000c 0 00000000
0f006593 0000002c 1 0b 000000f0 0 00000000
00100633 00000030 1 0c 00000005 0 00000000
00508463 00000034 0 00 00000000 0 00000000
00114663 00000038 0 00 00000000 1 00000044
05500693 0000003c 0 00 00000000 0 00000000
00116463 00000044 0 00 00000000 0 00000000
0020d863 00000048 0 00 00000000 1 00000058
05500693 0000004c 0 00 00000000 0 00000000
0200076f 00000058 1 0e 0000005c 1 00000078
00100793 0000005c 0 00 00000000 0 00000000
09100813 00000078 1 10 00000091 0 00000000
03c5f893 0000007c 1 11 00000030 0 00000000
01080967 00000080 1 12 00000084 1 000000a0
00100993 00000084 0 00 00000000 0 00000000
01270a33 000000a0 1 14 000000e0 0 00000000
00409ab3 000000a4 1 15 00000014 0 00000000
00415b33 000000a8 1 16 3fffffff 0 00000000

//--- coreTop.f
src/rvPkg.sv
src/controlDecoder.sv
src/decodeStage.sv
src/regFile.sv
src/executeStage.sv
src/coreTop.sv
verification/coreTopTb.sv

//--- runSim.sh
#!/bin/sh
# build and run coreTopTb with Verilator, pass only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f coreTop.f --top-module coreTopTb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/VcoreTopTb > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "Testbench passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
